//--- src.f
hw/bfifo_pkg.sv
hw/ppfifo.sv
hw/block_writer.sv
hw/bfifo_to_axis.sv
hw/bfifo_axis_top.sv
verif/tb_bfifo_axis.sv

//--- Makefile
# Verilator build, run and lint for the block FIFO stream source

VERILATOR  ?= verilator
TOP        := tb_bfifo_axis
FILELIST   := src.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
PASS_MSG   := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- verif/tb_bfifo_axis.sv
// #########################################################
// Testbench for the block FIFO stream source. Random words
// go in over req/ack and a queue model predicts the stream
// #########################################################

`default_nettype none

module tb_bfifo_axis;

  timeunit 1ns;
  timeprecision 100ps;

  import bfifo_pkg::*;

  localparam int DATA_WIDTH     = DEFAULT_DATA_WIDTH;
  localparam int ADDR_WIDTH     = DEFAULT_ADDR_WIDTH;
  localparam int DEPTH          = 1 << ADDR_WIDTH;
  localparam logic [31:0] SEED  = 32'd25810;
  // Upper bound on words sent with a per-word cycle budget
  localparam int MAX_WORDS      = 400;
  localparam int TIMEOUT_CYCLES = MAX_WORDS * 12 + 1000;
  // Ready held low long enough for the writer to fill both banks
  localparam int STALL_CYCLES   = 12 * DEPTH;

  logic                   i_axi_clk;
  logic                   rst;
  logic                   i_req;
  logic                   o_ack;
  logic [DATA_WIDTH-1:0]  i_data;
  logic                   i_sof;
  logic                   i_eob;
  logic                   i_axi_ready;
  logic                   o_axi_valid;
  logic [DATA_WIDTH-1:0]  o_axi_data;
  logic                   o_axi_last;
  axi_user_t              o_axi_user;

  // Model entries are {sof, last, data}
  logic [DATA_WIDTH+1:0]  model_q [$];
  logic [DATA_WIDTH+1:0]  exp_word;
  int                     blk_count;
  int                     cycle_count;
  int                     stall_left;
  logic [31:0]            prod_rng;
  logic [31:0]            rdy_rng;
  logic                   ready_random;
  string                  test_name;

  bfifo_axis_top #(
    .DATA_WIDTH  (DATA_WIDTH),
    .ADDR_WIDTH  (ADDR_WIDTH)
  ) i_bfifo_axis_top (
    .i_axi_clk   (i_axi_clk),
    .rst         (rst),
    .i_req       (i_req),
    .o_ack       (o_ack),
    .i_data      (i_data),
    .i_sof       (i_sof),
    .i_eob       (i_eob),
    .i_axi_ready (i_axi_ready),
    .o_axi_valid (o_axi_valid),
    .o_axi_data  (o_axi_data),
    .o_axi_last  (o_axi_last),
    .o_axi_user  (o_axi_user)
  );

  // 4 ns period
  always #2 i_axi_clk = ~i_axi_clk;

  // #########################################################
  // Helpers
  // #########################################################

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Producer side random stream
  function automatic logic [31:0] next_rand();
    prod_rng = xorshift32(prod_rng);
    return prod_rng;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic compare_value(input string what, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      fail_run($sformatf("ERR %s %s expected 0x%0h actual 0x%0h",
                         test_name, what, exp_val, act_val));
    end
  endtask

  // One four-phase transfer with the word queued in the model first
  task automatic send_word(input logic [DATA_WIDTH-1:0] data, input logic sof,
                           input logic eob);
    logic exp_last;
    // Bank closes on eob or on its last slot
    exp_last = eob || (blk_count == DEPTH - 1);
    blk_count = exp_last ? 0 : blk_count + 1;
    model_q.push_back({sof, exp_last, data});
    @(posedge i_axi_clk);
    #1;
    i_req  = 1'b1;
    i_data = data;
    i_sof  = sof;
    i_eob  = eob;
    @(posedge i_axi_clk);
    #1;
    while (!o_ack) begin
      @(posedge i_axi_clk);
      #1;
    end
    i_req = 1'b0;
    // Return to zero before the next word
    while (o_ack) begin
      @(posedge i_axi_clk);
      #1;
    end
  endtask

  // Block with sof on the first word and eob on the last
  task automatic send_block(input int len, input int max_gap);
    logic [31:0] r;
    int          gap;
    for (int i = 0; i < len; i++) begin
      r = next_rand();
      send_word(r[DATA_WIDTH-1:0], i == 0, i == len - 1);
      gap = int'(next_rand() % 32'(max_gap + 1));
      repeat (gap) @(posedge i_axi_clk);
    end
  endtask

  task automatic wait_drain();
    while (model_q.size() != 0) begin
      @(posedge i_axi_clk);
    end
    repeat (4) @(posedge i_axi_clk);
  endtask

  // #########################################################
  // Ready driver, monitor and timeout
  // #########################################################

  always @(posedge i_axi_clk) begin
    #1;
    rdy_rng = xorshift32(rdy_rng);
    if (stall_left > 0) begin
      stall_left  = stall_left - 1;
      i_axi_ready = 1'b0;
    end else begin
      i_axi_ready = ready_random ? rdy_rng[7] : 1'b1;
    end
  end

  // Sample mid-cycle since a beat moves on the next rising edge
  always @(negedge i_axi_clk) begin
    if (!rst && o_axi_valid && i_axi_ready) begin
      if (model_q.size() == 0) begin
        fail_run($sformatf("Stream word 0x%0h appeared in test %s with no word left",
                           o_axi_data, test_name));
      end else begin
        exp_word = model_q.pop_front();
        compare_value("data", 32'(exp_word[DATA_WIDTH-1:0]), 32'(o_axi_data));
        compare_value("last", 32'(exp_word[DATA_WIDTH]), 32'(o_axi_last));
        compare_value("user", 32'({3'b000, exp_word[DATA_WIDTH+1]}), 32'(o_axi_user));
      end
    end
  end

  always @(posedge i_axi_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout after %0d cycles in test %s, %0d words not seen",
                         cycle_count, test_name, model_q.size()));
    end
  end

  // #########################################################
  // Test sequence
  // #########################################################

  initial begin
    int          len;
    logic [31:0] r;
    i_axi_clk    = 1'b0;
    rst          = 1'b1;
    i_req        = 1'b0;
    i_data       = '0;
    i_sof        = 1'b0;
    i_eob        = 1'b0;
    i_axi_ready  = 1'b1;
    ready_random = 1'b0;
    blk_count    = 0;
    cycle_count  = 0;
    stall_left   = 0;
    prod_rng     = SEED;
    // Ready has its own stream derived from the same seed
    rdy_rng      = xorshift32(SEED ^ 32'h5bd1_e995);
    test_name    = "reset";
    repeat (16) @(posedge i_axi_clk);
    #1;
    rst = 1'b0;

    // Nothing moves without a request
    test_name = "idle";
    repeat (8) begin
      @(posedge i_axi_clk);
      #1;
      compare_value("ack", 32'h0, 32'(o_ack));
      compare_value("valid", 32'h0, 32'(o_axi_valid));
    end

    test_name = "short_eob";
    repeat (10) begin
      len = 1 + int'(next_rand() % 6);
      send_block(len, 3);
    end
    wait_drain();

    // Runs longer than two banks split on every full bank
    test_name = "long_runs";
    repeat (3) begin
      len = 2 * DEPTH + 1 + int'(next_rand() % 16);
      send_block(len, 1);
    end
    wait_drain();

    // Stalls on the stream fill both banks and hold off ack
    test_name = "random_ready";
    ready_random = 1'b1;
    stall_left   = STALL_CYCLES;
    for (int n = 0; n < 120; n++) begin
      r = next_rand();
      send_word(r[DATA_WIDTH-1:0], r[28], (r[31:29] == 3'b000) || (n == 119));
    end
    wait_drain();
    ready_random = 1'b0;

    test_name = "single_word";
    repeat (30) begin
      send_block(1, 0);
    end
    wait_drain();

    // Catch any word that comes out late
    test_name = "final";
    repeat (20) @(posedge i_axi_clk);
    if (model_q.size() == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      fail_run($sformatf("%0d words were sent but never seen on the stream",
                         model_q.size()));
    end
  end

endmodule

`default_nettype wire

//--- hw/bfifo_axis_top.sv
// #########################################################
// Top level of the stream source. Producer words pass
// through the block writer and the ping-pong buffer and
// leave as AXI Stream bursts
// #########################################################

`default_nettype none

module bfifo_axis_top #(
  parameter int DATA_WIDTH = bfifo_pkg::DEFAULT_DATA_WIDTH,
  parameter int ADDR_WIDTH = bfifo_pkg::DEFAULT_ADDR_WIDTH
) (
  input  wire                           i_axi_clk,
  input  wire                           rst,
  // Producer handshake
  input  wire                           i_req,
  output logic                          o_ack,
  input  wire [DATA_WIDTH-1:0]          i_data,
  input  wire                           i_sof,
  input  wire                           i_eob,
  // AXI Stream master
  input  wire                           i_axi_ready,
  output logic                          o_axi_valid,
  output logic [DATA_WIDTH-1:0]         o_axi_data,
  output logic                          o_axi_last,
  output bfifo_pkg::axi_user_t          o_axi_user
);

  import bfifo_pkg::*;

  // Writer to buffer
  wire bank_sel_t            wr_rdy;
  wire bank_sel_t            wr_act;
  wire                       wr_stb;
  wire [DATA_WIDTH:0]        wr_data;

  // Buffer to adapter
  wire                       rd_rdy;
  wire                       rd_act;
  wire                       rd_stb;
  wire bfifo_count_t         rd_size;
  wire [DATA_WIDTH:0]        rd_data;

  block_writer #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_block_writer (
    .i_axi_clk  (i_axi_clk),
    .rst        (rst),
    .i_req      (i_req),
    .o_ack      (o_ack),
    .i_data     (i_data),
    .i_sof      (i_sof),
    .i_eob      (i_eob),
    .i_wr_rdy   (wr_rdy),
    .o_wr_act   (wr_act),
    .o_wr_stb   (wr_stb),
    .o_wr_data  (wr_data)
  );

  ppfifo #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_ppfifo (
    .i_axi_clk  (i_axi_clk),
    .rst        (rst),
    .o_wr_rdy   (wr_rdy),
    .i_wr_act   (wr_act),
    .i_wr_stb   (wr_stb),
    .i_wr_data  (wr_data),
    .o_rd_rdy   (rd_rdy),
    .i_rd_act   (rd_act),
    .i_rd_stb   (rd_stb),
    .o_rd_size  (rd_size),
    .o_rd_data  (rd_data)
  );

  bfifo_to_axis #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_bfifo_to_axis (
    .i_axi_clk    (i_axi_clk),
    .rst          (rst),
    .i_bfifo_rdy  (rd_rdy),
    .o_bfifo_act  (rd_act),
    .i_bfifo_size (rd_size),
    .i_bfifo_data (rd_data),
    .o_bfifo_stb  (rd_stb),
    .i_axi_ready  (i_axi_ready),
    .o_axi_valid  (o_axi_valid),
    .o_axi_data   (o_axi_data),
    .o_axi_last   (o_axi_last),
    .o_axi_user   (o_axi_user)
  );

endmodule

`default_nettype wire

//--- hw/bfifo_to_axis.sv
// #########################################################
// Drains one closed bank of the block FIFO as an AXI Stream
// burst. Last marks the final word of the bank and user
// bit 0 carries the start-of-frame flag
// #########################################################

`default_nettype none

module bfifo_to_axis #(
  parameter int DATA_WIDTH = bfifo_pkg::DEFAULT_DATA_WIDTH
) (
  input  wire                           i_axi_clk,
  input  wire                           rst,
  // Block FIFO read side
  input  wire                           i_bfifo_rdy,
  output logic                          o_bfifo_act,
  input  wire bfifo_pkg::bfifo_count_t  i_bfifo_size,
  input  wire [DATA_WIDTH:0]            i_bfifo_data,
  output logic                          o_bfifo_stb,
  // AXI Stream master
  input  wire                           i_axi_ready,
  output logic                          o_axi_valid,
  output logic [DATA_WIDTH-1:0]         o_axi_data,
  output logic                          o_axi_last,
  output bfifo_pkg::axi_user_t          o_axi_user
);

  import bfifo_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READY,
    ST_RELEASE
  } adapter_state_t;

  adapter_state_t  state;
  // Words already sent from the current bank
  bfifo_count_t    r_count;
  bfifo_count_t    next_count;
  logic            words_left;

  assign next_count = r_count + 1'b1;
  assign words_left = (r_count < i_bfifo_size);

  // #########################################################
  // Stream outputs
  // #########################################################

  // Payload comes straight from the bank at the read pointer
  assign o_axi_data  = i_bfifo_data[DATA_WIDTH-1:0];
  // Every accepted beat advances the read pointer
  assign o_bfifo_stb = i_axi_ready & o_axi_valid;
  // Flag only while a word is pending, upper user bits unused
  assign o_axi_user  = {3'b000, words_left & i_bfifo_data[DATA_WIDTH]};
  assign o_axi_last  = (next_count >= i_bfifo_size) & o_bfifo_act & o_axi_valid;

  // #########################################################
  // Burst control
  // #########################################################

  always_ff @(posedge i_axi_clk) begin
    if (rst) begin
      state       <= ST_IDLE;
      o_bfifo_act <= 1'b0;
      o_axi_valid <= 1'b0;
      r_count     <= '0;
    end else begin
      o_axi_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          o_bfifo_act <= 1'b0;
          // Claim the next closed bank
          if (i_bfifo_rdy && !o_bfifo_act) begin
            r_count     <= '0;
            o_bfifo_act <= 1'b1;
            state       <= ST_READY;
          end
        end
        ST_READY: begin
          if (words_left) begin
            // Valid stays up through stalls
            o_axi_valid <= 1'b1;
            if (o_bfifo_stb) begin
              r_count <= next_count;
              // Final beat taken, drop valid
              if (next_count >= i_bfifo_size) begin
                o_axi_valid <= 1'b0;
              end
            end
          end else begin
            // Bank sent, give it back
            o_bfifo_act <= 1'b0;
            state       <= ST_RELEASE;
          end
        end
        ST_RELEASE: begin
          // One idle cycle so the buffer sees act low
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/block_writer.sv
// #########################################################
// Producer side of the block FIFO. Takes words over a
// four-phase req/ack handshake and packs them into one bank
// until end of block or the bank runs full
// #########################################################

`default_nettype none

module block_writer #(
  parameter int DATA_WIDTH = bfifo_pkg::DEFAULT_DATA_WIDTH,
  parameter int ADDR_WIDTH = bfifo_pkg::DEFAULT_ADDR_WIDTH
) (
  input  wire                           i_axi_clk,
  input  wire                           rst,
  // Producer handshake
  input  wire                           i_req,
  output logic                          o_ack,
  input  wire [DATA_WIDTH-1:0]          i_data,
  input  wire                           i_sof,
  input  wire                           i_eob,
  // Block FIFO write side
  input  wire bfifo_pkg::bank_sel_t     i_wr_rdy,
  output bfifo_pkg::bank_sel_t          o_wr_act,
  output logic                          o_wr_stb,
  output logic [DATA_WIDTH:0]           o_wr_data
);

  import bfifo_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CLAIM,
    ST_WRITE,
    ST_WAIT_REL
  } writer_state_t;

  writer_state_t           state;
  bank_sel_t               claim_sel;
  logic [ADDR_WIDTH-1:0]   wr_count;
  logic                    new_req;

  // Lowest set bit of the ready mask
  assign claim_sel = i_wr_rdy & (~i_wr_rdy + 2'b01);

  // A request counts only once ack from the last word is gone
  assign new_req = i_req & ~o_ack;

  // Word register, start of frame rides in the top bit
  always_ff @(posedge i_axi_clk) begin
    if ((state == ST_WRITE) && new_req) begin
      o_wr_data <= {i_sof, i_data};
    end
  end

  // #########################################################
  // Handshake and bank control
  // #########################################################

  always_ff @(posedge i_axi_clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      o_ack    <= 1'b0;
      o_wr_act <= '0;
      o_wr_stb <= 1'b0;
      wr_count <= '0;
    end else begin
      o_wr_stb <= 1'b0;

      // Return to zero once the producer drops req
      if (o_ack && !i_req) begin
        o_ack <= 1'b0;
      end

      case (state)
        ST_IDLE: begin
          // No bank held, wait for demand
          if (new_req) begin
            state <= ST_CLAIM;
          end
        end
        ST_CLAIM: begin
          if (|i_wr_rdy) begin
            o_wr_act <= claim_sel;
            wr_count <= '0;
            state    <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          if (new_req) begin
            o_ack    <= 1'b1;
            o_wr_stb <= 1'b1;
            wr_count <= wr_count + 1'b1;
            // All ones means this is the last slot of the bank
            if (i_eob || (&wr_count)) begin
              state <= ST_WAIT_REL;
            end
          end
        end
        ST_WAIT_REL: begin
          // Closing word has been strobed, hand the bank over
          o_wr_act <= '0;
          state    <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/ppfifo.sv
// #########################################################
// Two-bank ping-pong block FIFO. The writer claims an empty
// bank and fills it, the reader takes closed banks in the
// order they were closed and releases them when done
// #########################################################

`default_nettype none

module ppfifo #(
  parameter int DATA_WIDTH = bfifo_pkg::DEFAULT_DATA_WIDTH,
  parameter int ADDR_WIDTH = bfifo_pkg::DEFAULT_ADDR_WIDTH
) (
  input  wire                           i_axi_clk,
  input  wire                           rst,
  // Write side
  output bfifo_pkg::bank_sel_t          o_wr_rdy,
  input  wire bfifo_pkg::bank_sel_t     i_wr_act,
  input  wire                           i_wr_stb,
  input  wire [DATA_WIDTH:0]            i_wr_data,
  // Read side
  output logic                          o_rd_rdy,
  input  wire                           i_rd_act,
  input  wire                           i_rd_stb,
  output bfifo_pkg::bfifo_count_t       o_rd_size,
  output logic [DATA_WIDTH:0]           o_rd_data
);

  import bfifo_pkg::*;

  localparam int DEPTH = 1 << ADDR_WIDTH;

  // Life cycle of one bank
  typedef enum logic [1:0] {
    BANK_EMPTY,
    BANK_FILLING,
    BANK_FULL,
    BANK_DRAINING
  } bank_state_t;

  bank_state_t             bank_state [2];
  bfifo_count_t            bank_size  [2];
  logic [DATA_WIDTH:0]     mem        [2][DEPTH];

  // Write pointer has one extra bit so a full bank reads as DEPTH
  logic [ADDR_WIDTH:0]     wr_ptr;
  logic [ADDR_WIDTH-1:0]   rd_ptr;
  // Bank that closed first and is next in line for the reader
  logic                    rd_sel;
  logic                    rd_idx;
  logic                    wr_idx;
  logic                    wr_claim;
  logic                    wr_en;
  logic                    draining;

  // #########################################################
  // Status and selection
  // #########################################################

  always_comb begin
    for (int b = 0; b < 2; b++) begin
      o_wr_rdy[b] = (bank_state[b] == BANK_EMPTY);
    end
  end

  assign draining = (bank_state[0] == BANK_DRAINING) | (bank_state[1] == BANK_DRAINING);

  // Only one bank may be read at a time
  assign o_rd_rdy = (bank_state[rd_sel] == BANK_FULL) & ~draining;

  // Read outputs follow the draining bank, else the next one in line
  always_comb begin
    if (bank_state[1] == BANK_DRAINING) begin
      rd_idx = 1'b1;
    end else if (bank_state[0] == BANK_DRAINING) begin
      rd_idx = 1'b0;
    end else begin
      rd_idx = rd_sel;
    end
  end

  assign o_rd_size = bank_size[rd_idx];
  assign o_rd_data = mem[rd_idx][rd_ptr];

  // Writer holds at most one bank, so act is one-hot here
  assign wr_idx   = i_wr_act[1];
  assign wr_claim = |(i_wr_act & o_wr_rdy);
  assign wr_en    = i_wr_stb & (|i_wr_act) & (bank_state[wr_idx] == BANK_FILLING) &
                    ~wr_ptr[ADDR_WIDTH];

  // #########################################################
  // Bank state, pointers and sizes
  // #########################################################

  always_ff @(posedge i_axi_clk) begin
    if (rst) begin
      bank_state <= '{BANK_EMPTY, BANK_EMPTY};
      bank_size  <= '{'0, '0};
      rd_sel     <= 1'b0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
    end else begin
      for (int b = 0; b < 2; b++) begin
        case (bank_state[b])
          BANK_EMPTY: begin
            if (i_wr_act[b]) begin
              bank_state[b] <= BANK_FILLING;
            end
          end
          BANK_FILLING: begin
            // Writer let go, size is the number of words written
            if (!i_wr_act[b]) begin
              bank_state[b] <= BANK_FULL;
              bank_size[b]  <= bfifo_count_t'(wr_ptr);
              // Other bank still waiting keeps its place in line
              if (bank_state[1 - b] != BANK_FULL) begin
                rd_sel <= 1'(b);
              end
            end
          end
          BANK_FULL: begin
            if (i_rd_act && !draining && (rd_sel == 1'(b))) begin
              bank_state[b] <= BANK_DRAINING;
            end
          end
          BANK_DRAINING: begin
            // Reader let go, bank is free for the writer again
            if (!i_rd_act) begin
              bank_state[b] <= BANK_EMPTY;
            end
          end
          default: begin
            bank_state[b] <= BANK_EMPTY;
          end
        endcase
      end

      // Fill pointer restarts on every new claim
      if (wr_claim) begin
        wr_ptr <= '0;
      end else if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end

      // Read pointer sits at zero between bursts
      if (!draining) begin
        rd_ptr <= '0;
      end else if (i_rd_stb) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Bank storage
  always_ff @(posedge i_axi_clk) begin
    if (wr_en) begin
      mem[wr_idx][wr_ptr[ADDR_WIDTH-1:0]] <= i_wr_data;
    end
  end

endmodule

`default_nettype wire

//--- hw/bfifo_pkg.sv
// #########################################################
// Shared types and default sizes for the block FIFO stream
// source. Imported by every RTL module of the subsystem
// #########################################################

`default_nettype none

package bfifo_pkg;

  // #########################################################
  // Types
  // #########################################################

  // Word count of one bank, as carried on the size port
  typedef logic [23:0] bfifo_count_t;

  // AXI Stream user field, bit 0 is start of frame
  typedef logic [3:0] axi_user_t;

  // One-hot mask over the two banks
  typedef logic [1:0] bank_sel_t;

  // #########################################################
  // Defaults for the top level
  // #########################################################
  localparam int DEFAULT_DATA_WIDTH = 24;
  // 16 words per bank
  localparam int DEFAULT_ADDR_WIDTH = 4;

endpackage

`default_nettype wire
